// File: Makefile
SIM  := obj_dir/Vvxs_tb
SRCS := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
$(SIM): build.f $(SRCS) hdl/vxs_config.svh
	verilator --binary --timing --assert -j 0 -f build.f --top-module vxs_tb

# pass only if the log holds the pass line
run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx 'NO ERRORS' sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+hdl
hdl/vxs_pkg.sv
hdl/lane_rshift.sv
hdl/fxp_round.sv
hdl/vxs_lane.sv
hdl/vxs_issue.sv
hdl/vxs_collect.sv
hdl/vxs_top.sv
verification/tb_clock.sv
verification/vxs_tb.sv

// File: hdl/fxp_round.sv
`default_nettype none

module fxp_round #(
	parameter int DATA_WIDTH = 64
) (
	input  var vxs_pkg::vxrm_e     vxrm,
	input  var vxs_pkg::sew_e      sew,
	input  wire [DATA_WIDTH/8-1:0] v_d,
	input  wire [DATA_WIDTH/8-1:0] v_d1,
	input  wire [DATA_WIDTH/8-1:0] v_d10,
	input  wire [DATA_WIDTH-1:0]   vec_in,
	input  wire                    in_valid,
	output logic [DATA_WIDTH-1:0]  vec_out
);
	import vxs_pkg::*;

	localparam int DW_B = DATA_WIDTH / 8;

	// increment per byte, only element-lowest bytes can be set
	logic [DW_B-1:0]       r;
	// bytes per element minus one
	logic [2:0]            seg_mask;
	logic [DATA_WIDTH-1:0] sum;

	always_comb begin
		case (vxrm)
			VXRM_RNU: r = v_d1;
			// ties go to even
			VXRM_RNE: r = v_d1 & (v_d10 | v_d);
			// jam a one into an even result if anything was lost
			VXRM_ROD: r = ~v_d & (v_d1 | v_d10);
			default:  r = '0;
		endcase
	end

	assign seg_mask = ~(3'b111 << sew);

	// byte-wide ripple, chain cut at each element start
	always_comb begin
		logic [8:0] bsum;
		logic       carry;
		carry = 1'b0;
		for (int i = 0; i < DW_B; i++) begin
			if ((3'(i) & seg_mask) == 3'd0) begin
				carry = 1'b0;
			end
			bsum = {1'b0, vec_in[i*8 +: 8]} + 9'(r[i]) + 9'(carry);
			sum[i*8 +: 8] = bsum[7:0];
			// carry out of the element's top byte is dropped
			carry = bsum[8];
		end
	end

	assign vec_out = in_valid ? sum : '0;

endmodule

`default_nettype wire

// File: hdl/lane_rshift.sv
`default_nettype none

module lane_rshift #(
	parameter int DATA_WIDTH = 64
) (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     advance,
	input  var vxs_pkg::lane_op_t   op,
	output logic [DATA_WIDTH-1:0]   vec_out,
	output logic [DATA_WIDTH/8-1:0] v_d,
	output logic [DATA_WIDTH/8-1:0] v_d1,
	output logic [DATA_WIDTH/8-1:0] v_d10,
	output vxs_pkg::sew_e           sew_out,
	output vxs_pkg::vxrm_e          vxrm_out
);
	localparam int DW_B = DATA_WIDTH / 8;

	// one candidate per sew, op.sew picks one
	logic [DATA_WIDTH-1:0] sh_sew  [4];
	logic [DW_B-1:0]       d_sew   [4];
	logic [DW_B-1:0]       d1_sew  [4];
	logic [DW_B-1:0]       d10_sew [4];

	for (genvar k = 0; k < 4; k++) begin : g_sew
		// element width, shift bits, elements per chunk, bytes per element
		localparam int EW = 8 << k;
		localparam int SW = k + 3;
		localparam int NE = DATA_WIDTH / EW;
		localparam int EB = EW / 8;

		logic [SW-1:0]         s;
		logic [DATA_WIDTH-1:0] sh;
		logic [DW_B-1:0]       d;
		logic [DW_B-1:0]       d1;
		logic [DW_B-1:0]       d10;

		// only this sew's low bits, keeps the bit selects in range
		assign s = op.shift[SW-1:0];

		always_comb begin
			logic [EW-1:0] elem;
			logic [EW-1:0] fill;
			logic [EW-1:0] lo_mask;
			sh  = '0;
			d   = '0;
			d1  = '0;
			d10 = '0;
			for (int j = 0; j < NE; j++) begin
				elem = op.data[j*EW +: EW];
				// sign copies for arithmetic, zeros otherwise
				fill = {EW{op.arith & elem[EW-1]}};
				sh[j*EW +: EW] = (elem >> s) | (fill & ~({EW{1'b1}} >> s));
				// bits below s-1, empty for s of 0 or 1
				lo_mask = ~({EW{1'b1}} << s) >> 1;
				// flags sit in the element's lowest byte
				d[j*EB]   = elem[s];
				d1[j*EB]  = (s != '0) & elem[s - 1'b1];
				d10[j*EB] = |(elem & lo_mask);
			end
		end

		assign sh_sew[k]  = sh;
		assign d_sew[k]   = d;
		assign d1_sew[k]  = d1;
		assign d10_sew[k] = d10;
	end

	// shift stage register
	always_ff @(posedge clk) begin
		if (advance) begin
			vec_out  <= sh_sew[op.sew];
			v_d      <= d_sew[op.sew];
			v_d1     <= d1_sew[op.sew];
			v_d10    <= d10_sew[op.sew];
			sew_out  <= op.sew;
			vxrm_out <= op.vxrm;
		end
	end

	// issue masked the shift, so it stays below the element width
	a_shift_fits: assert property (@(posedge clk) disable iff (!rst_n)
		(advance && !$isunknown(op)) |-> ({1'b0, op.shift} < (7'd8 << op.sew)))
		else $error("lane_rshift: shift %0d too wide for sew %0d", op.shift, op.sew);

endmodule

`default_nettype wire

// File: hdl/vxs_collect.sv
`default_nettype none

`include "vxs_config.svh"

module vxs_collect (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire  [`VXS_LANES-1:0]                 lane_valid,
	input  wire  [`VXS_LANES-1:0][`VXS_ELEN-1:0]  lane_res,
	input  wire  [`VXS_TAG_W-1:0]                 tag_in,
	input  wire                                   out_ready,
	output logic                                  out_valid,
	output vxs_pkg::vxs_res_t                     out_res,
	output logic                                  advance
);
	// tag follows the shift and lane output stages
	logic [`VXS_TAG_W-1:0] tag_d1;
	logic [`VXS_TAG_W-1:0] tag_d2;

	// whole pipe moves when the result slot is free or being taken
	assign advance = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (advance) begin
			tag_d1 <= tag_in;
			tag_d2 <= tag_d1;
		end
	end

	// result register
	// lane 0 lands in the low chunk
	always_ff @(posedge clk) begin
		if (advance) begin
			out_res.data <= lane_res;
			out_res.tag  <= tag_d2;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= &lane_valid;
		end
	end

	// lanes share one valid from issue, so they move in lockstep
	a_lanes_agree: assert property (@(posedge clk) disable iff (!rst_n)
		(lane_valid == '0) || (&lane_valid))
		else $error("vxs_collect: lane valid bits disagree %b", lane_valid);

	// held result stays put until taken
	a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_res)))
		else $error("vxs_collect: result changed or dropped while stalled");

endmodule

`default_nettype wire

// File: hdl/vxs_config.svh
`ifndef VXS_CONFIG_SVH
`define VXS_CONFIG_SVH

// lanes working side by side on one request
`define VXS_LANES 4

// bits handled by each lane
// lane_rshift and fxp_round expect a multiple of 64
`define VXS_ELEN 64

// request tag, returned unchanged with the result
`define VXS_TAG_W 4

`endif

// File: hdl/vxs_issue.sv
`default_nettype none

`include "vxs_config.svh"

module vxs_issue (
	input  wire                                clk,
	input  wire                                rst_n,
	input  wire                                in_valid,
	input  var vxs_pkg::vxs_req_t              in_req,
	input  wire                                advance,
	output logic                               lane_valid,
	output vxs_pkg::lane_op_t [`VXS_LANES-1:0] lane_op,
	output logic [`VXS_TAG_W-1:0]              tag
);
	import vxs_pkg::*;

	// shift after masking to log2 of the element width
	logic [5:0] shift_m;

	// decided once here so the lanes never repeat it
	always_comb begin
		case (in_req.sew)
			SEW_8: begin
				shift_m = {3'b000, in_req.shift[2:0]};
			end
			SEW_16: begin
				shift_m = {2'b00, in_req.shift[3:0]};
			end
			SEW_32: begin
				shift_m = {1'b0, in_req.shift[4:0]};
			end
			default: begin
				shift_m = in_req.shift;
			end
		endcase
	end

	// one valid for all lanes, they always run together
	// a bubble moves in when nothing is offered
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lane_valid <= 1'b0;
		end else if (advance) begin
			lane_valid <= in_valid;
		end
	end

	// slice the vector, lane 0 takes the low chunk
	always_ff @(posedge clk) begin
		if (advance) begin
			for (int i = 0; i < `VXS_LANES; i++) begin
				lane_op[i].data  <= in_req.data[i*`VXS_ELEN +: `VXS_ELEN];
				lane_op[i].sew   <= in_req.sew;
				lane_op[i].shift <= shift_m;
				lane_op[i].arith <= in_req.arith;
				lane_op[i].vxrm  <= in_req.vxrm;
			end
			// tag skips the lanes, collector lines it up again
			tag <= in_req.tag;
		end
	end

	// offered requests must be fully driven
	a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown(in_req))
		else $error("vxs_issue: request has X/Z while in_valid is high");

endmodule

`default_nettype wire

// File: hdl/vxs_lane.sv
`default_nettype none

`include "vxs_config.svh"

module vxs_lane (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  advance,
	input  wire                  op_valid,
	input  var vxs_pkg::lane_op_t op,
	output logic                 res_valid,
	output logic [`VXS_ELEN-1:0] res
);
	import vxs_pkg::*;

	// shift stage outputs
	logic                    sh_valid;
	logic [`VXS_ELEN-1:0]    sh_vec;
	logic [`VXS_ELEN/8-1:0]  sh_d;
	logic [`VXS_ELEN/8-1:0]  sh_d1;
	logic [`VXS_ELEN/8-1:0]  sh_d10;
	sew_e                    sh_sew;
	vxrm_e                   sh_vxrm;
	// rounded chunk, before the output register
	logic [`VXS_ELEN-1:0]    rnd_vec;

	lane_rshift #(
		.DATA_WIDTH(`VXS_ELEN)
	) u_rshift (
		.clk     (clk),
		.rst_n   (rst_n),
		.advance (advance),
		.op      (op),
		.vec_out (sh_vec),
		.v_d     (sh_d),
		.v_d1    (sh_d1),
		.v_d10   (sh_d10),
		.sew_out (sh_sew),
		.vxrm_out(sh_vxrm)
	);

	fxp_round #(
		.DATA_WIDTH(`VXS_ELEN)
	) u_round (
		.vxrm    (sh_vxrm),
		.sew     (sh_sew),
		.v_d     (sh_d),
		.v_d1    (sh_d1),
		.v_d10   (sh_d10),
		.vec_in  (sh_vec),
		.in_valid(sh_valid),
		.vec_out (rnd_vec)
	);

	// valid follows the data through both stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sh_valid  <= 1'b0;
			res_valid <= 1'b0;
		end else if (advance) begin
			sh_valid  <= op_valid;
			res_valid <= sh_valid;
		end
	end

	// lane output register
	always_ff @(posedge clk) begin
		if (advance) begin
			res <= rnd_vec;
		end
	end

endmodule

`default_nettype wire

// File: hdl/vxs_pkg.sv
`default_nettype none

`include "vxs_config.svh"

package vxs_pkg;

	// element width encoding
	typedef enum logic [1:0] {
		SEW_8  = 2'b00,
		SEW_16 = 2'b01,
		SEW_32 = 2'b10,
		SEW_64 = 2'b11
	} sew_e;

	// fixed-point rounding modes, same codes as vxrm
	typedef enum logic [1:0] {
		VXRM_RNU = 2'b00,
		VXRM_RNE = 2'b01,
		VXRM_RDN = 2'b10,
		VXRM_ROD = 2'b11
	} vxrm_e;

	// full request as seen on the input port
	typedef struct packed {
		logic [`VXS_LANES*`VXS_ELEN-1:0] data;
		sew_e                            sew;
		logic [5:0]                      shift;
		logic                            arith;
		vxrm_e                           vxrm;
		logic [`VXS_TAG_W-1:0]           tag;
	} vxs_req_t;

	// one lane's share, shift already masked to the element width
	typedef struct packed {
		logic [`VXS_ELEN-1:0] data;
		sew_e                 sew;
		logic [5:0]           shift;
		logic                 arith;
		vxrm_e                vxrm;
	} lane_op_t;

	// gathered result
	typedef struct packed {
		logic [`VXS_LANES*`VXS_ELEN-1:0] data;
		logic [`VXS_TAG_W-1:0]           tag;
	} vxs_res_t;

endpackage

`default_nettype wire

// File: hdl/vxs_top.sv
`default_nettype none

`include "vxs_config.svh"

module vxs_top (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  in_valid,
	output logic                 in_ready,
	input  var vxs_pkg::vxs_req_t in_req,
	output logic                 out_valid,
	input  wire                  out_ready,
	output vxs_pkg::vxs_res_t    out_res
);
	import vxs_pkg::*;

	// common stall, from the collector
	logic                                 advance;
	// issue register contents
	logic                                 issue_valid;
	lane_op_t [`VXS_LANES-1:0]            lane_op;
	logic [`VXS_TAG_W-1:0]                issue_tag;
	// lane output registers
	logic [`VXS_LANES-1:0]                lane_valid;
	logic [`VXS_LANES-1:0][`VXS_ELEN-1:0] lane_res;

	// accept whenever the pipe moves
	assign in_ready = advance;

	vxs_issue u_issue (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.advance   (advance),
		.lane_valid(issue_valid),
		.lane_op   (lane_op),
		.tag       (issue_tag)
	);

	for (genvar i = 0; i < `VXS_LANES; i++) begin : g_lane
		vxs_lane u_lane (
			.clk      (clk),
			.rst_n    (rst_n),
			.advance  (advance),
			.op_valid (issue_valid),
			.op       (lane_op[i]),
			.res_valid(lane_valid[i]),
			.res      (lane_res[i])
		);
	end

	vxs_collect u_collect (
		.clk       (clk),
		.rst_n     (rst_n),
		.lane_valid(lane_valid),
		.lane_res  (lane_res),
		.tag_in    (issue_tag),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_res   (out_res),
		.advance   (advance)
	);

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);
	// period 4
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// low for 5 edges, released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verification/vxs_tb.sv
`default_nettype none

`include "vxs_config.svh"

module vxs_tb;
	import vxs_pkg::*;

	localparam int DW = `VXS_LANES * `VXS_ELEN;
	localparam int TAG_W = `VXS_TAG_W;
	localparam int PERIOD = 4;
	// random valid and ready first and a steady stream after
	localparam int NUM_RAND = 300;
	localparam int NUM_STEADY = 100;
	localparam int NUM_REQ = NUM_RAND + NUM_STEADY;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	logic     in_ready;
	vxs_req_t in_req;
	logic     out_valid;
	logic     out_ready;
	vxs_res_t out_res;

	logic [31:0] lfsr = 32'h64f3_7414;
	// scoreboard with the acceptance edge kept for the latency check
	vxs_res_t    exp_q[$];
	int          acc_q[$];
	int          cyc = 0;
	int          offered = 0;
	int          accepted = 0;
	int          checked = 0;
	logic        steady = 1'b0;
	logic        held = 1'b0;
	vxs_res_t    held_res;

	tb_clock u_clock (
		.clk  (clk),
		.rst_n(rst_n)
	);

	vxs_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_req   (in_req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res  (out_res)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic vxs_req_t random_request();
		vxs_req_t   r;
		logic [1:0] kind;
		kind = 2'(rand_bits(2));
		for (int i = 0; i < `VXS_LANES; i++) begin
			r.data[i*`VXS_ELEN +: `VXS_ELEN] = `VXS_ELEN'(rand_bits(64));
		end
		case (kind)
			// all ones so the increment has to wrap
			2'd1: r.data = '1;
			// sparse bits give rne ties and lone sticky bits
			2'd2: begin
				for (int i = 0; i < `VXS_LANES; i++) begin
					r.data[i*`VXS_ELEN +: `VXS_ELEN] &=
						`VXS_ELEN'(rand_bits(64) & rand_bits(64));
				end
			end
			// top bit of every byte set so negative at any sew
			2'd3: r.data = r.data | {(DW / 8){8'h80}};
			default: ;
		endcase
		r.sew   = sew_e'(2'(rand_bits(2)));
		r.shift = 6'(rand_bits(6));
		if (rand_bits(3) == '0) begin
			r.shift = '0;
		end
		r.arith = 1'(rand_bits(1));
		r.vxrm  = vxrm_e'(2'(rand_bits(2)));
		r.tag   = TAG_W'(rand_bits(TAG_W));
		return r;
	endfunction

	// reference model working element by element
	function automatic vxs_res_t expected_result(input vxs_req_t r);
		vxs_res_t           res;
		logic [63:0]        mask;
		logic [63:0]        e;
		logic [63:0]        sh;
		logic signed [63:0] se;
		logic               inc;
		logic               sticky;
		int                 ew;
		int                 s;
		ew = 8 << int'(r.sew);
		s = int'(r.shift) % ew;
		mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
		res.data = '0;
		res.tag = r.tag;
		for (int k = 0; k < DW / ew; k++) begin
			e = 64'(r.data >> (k * ew)) & mask;
			if (r.arith && e[ew-1]) begin
				e = e | ~mask;
			end
			if (r.arith) begin
				se = e;
				se = se >>> s;
				sh = se & mask;
			end else begin
				sh = e >> s;
			end
			inc = 1'b0;
			if (s != 0) begin
				sticky = (s > 1) && ((e & ((64'd1 << (s - 1)) - 64'd1)) != '0);
				case (r.vxrm)
					VXRM_RNU: inc = e[s-1];
					VXRM_RNE: inc = e[s-1] & (sticky | e[s]);
					VXRM_RDN: inc = 1'b0;
					default:  inc = !e[s] & (e[s-1] | sticky);
				endcase
			end
			sh = (sh + {63'd0, inc}) & mask;
			res.data = res.data | (DW'(sh) << (k * ew));
		end
		return res;
	endfunction

	task automatic compare_values(input string name, input logic [DW-1:0] expected,
			input logic [DW-1:0] actual);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %0h actual %0h",
				$time, name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	// sees the values from before the edge
	always @(posedge clk) begin : monitor
		vxs_res_t exp_r;
		int       acc;
		cyc = cyc + 1;
		if (rst_n) begin
			// a stalled result must still be there unchanged
			if (held) begin
				compare_values("out_valid while stalled", DW'(1), DW'(out_valid));
				compare_values("out_res.data while stalled", held_res.data, out_res.data);
				compare_values("out_res.tag while stalled", DW'(held_res.tag), DW'(out_res.tag));
			end
			held = out_valid && !out_ready;
			held_res = out_res;
			if (in_valid && in_ready) begin
				exp_q.push_back(expected_result(in_req));
				acc_q.push_back(steady ? cyc : -1);
				accepted++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					abort_run("output transfer with no request outstanding");
				end else begin
					exp_r = exp_q.pop_front();
					acc = acc_q.pop_front();
					compare_values("out_res.data", exp_r.data, out_res.data);
					compare_values("out_res.tag", DW'(exp_r.tag), DW'(out_res.tag));
					// taken on the fourth edge after the acceptance edge
					if (acc >= 0) begin
						compare_values("latency", DW'(4), DW'(cyc - acc));
					end
					checked++;
				end
			end
		end
	end

	// driver acting a small delay after each rising edge
	initial begin
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b0;
		wait (rst_n === 1'b1);
		@(posedge clk);
		#1;
		compare_values("in_ready after reset", DW'(1), DW'(in_ready));
		compare_values("out_valid after reset", DW'(0), DW'(out_valid));
		while (checked < NUM_REQ) begin
			@(posedge clk);
			#1;
			// payload held until the transfer
			if (!in_valid || accepted == offered) begin
				if (offered < NUM_REQ && (offered >= NUM_RAND || rand_bits(2) != '0)) begin
					in_req = random_request();
					in_valid = 1'b1;
					offered++;
				end else begin
					in_valid = 1'b0;
				end
			end
			steady = offered > NUM_RAND;
			out_ready = steady ? 1'b1 : (rand_bits(2) != '0);
		end
		// extra edges catch duplicate results
		repeat (8) @(posedge clk);
		if (exp_q.size() == 0 && checked == NUM_REQ) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run("scoreboard not empty at the end of the run");
		end
	end

	// watchdog
	initial begin
		#((NUM_REQ * 20 + 10) * PERIOD);
		$display("timeout: outputs stopped, %0d of %0d results checked", checked, NUM_REQ);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
